/* ddr_seq_top.f */
common/ddr_seq_pkg.sv
logic/cmd_mem.sv
sequencer/seq_regs.sv
sequencer/seq_ctrl.sv
logic/ddr_seq_top.sv
testbench/ddr_seq_checker.sv
testbench/ddr_seq_props.sv
testbench/ddr_seq_tb.sv

/* testbench/ddr_seq_tb.sv */
// clock and reset, sequence table, wishbone master tasks, lfsr stimulus, closing report
`timescale 1ns/1ps
`default_nettype none

module ddr_seq_tb;

    localparam int          n_rows     = 5;
    localparam int          ack_limit  = 16;     // cycles to wait for an ack
    localparam int          poll_limit = 200;    // status reads per sequence
    localparam logic [11:0] run_adr    = 12'h800 | 12'(ddr_seq_pkg::reg_run);
    localparam logic [11:0] stat_adr   = 12'h800 | 12'(ddr_seq_pkg::reg_status);

    typedef struct packed {
        logic       bank;
        logic [9:0] start;
        logic [7:0] count;                       // commands before the done nop
        logic [7:0] pause_pos;                   // commands ahead of the pause nop
        logic [5:0] pause_len;
        logic       second_go;                   // go again while busy
    } row_t;

    // count 0 reruns what the bank already holds
    row_t rows [0:n_rows-1] = '{
        '{1'b0, 10'h000, 8'd5, 8'd2, 6'd3,  1'b1},
        '{1'b1, 10'h000, 8'd4, 8'd1, 6'd1,  1'b0},
        '{1'b1, 10'h3c0, 8'd8, 8'd8, 6'd0,  1'b0},
        '{1'b0, 10'h200, 8'd3, 8'd0, 6'd63, 1'b1},
        '{1'b0, 10'h000, 8'd0, 8'd0, 6'd0,  1'b0}
    };

    logic                                  mclk;
    logic                                  rst;
    logic                                  wb_cyc;
    logic                                  wb_stb;
    logic                                  wb_we;
    logic [ddr_seq_pkg::wb_addr_bits-1:0]  wb_adr;
    logic [ddr_seq_pkg::wb_data_bits-1:0]  wb_dat_w;
    logic                                  wb_ack;
    logic [ddr_seq_pkg::wb_data_bits-1:0]  wb_dat_r;
    ddr_seq_pkg::ddr_cmd_t                 cmd;
    logic                                  cmd_valid;
    logic [31:0]                           lfsr;           // stimulus generator state
    int                                    tb_errors;
    int                                    chk_errors;

    ddr_seq_top #(.cmd_addr_bits(ddr_seq_pkg::cmd_addr_bits)) ddr_seq_top_inst (.*);

    ddr_seq_checker check_inst (.*, .errors(chk_errors));

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};    // taps 32, 22, 2, 1
    endfunction

    function automatic ddr_seq_pkg::cmd_word_u nop_word(input logic done, input logic [5:0] p);
        ddr_seq_pkg::cmd_word_u w;
        w           = '0;
        w.nop.cke   = 1'b1;
        w.nop.ras_n = 1'b1;
        w.nop.cas_n = 1'b1;
        w.nop.we_n  = 1'b1;
        w.nop.done  = done;
        w.nop.pause = p;
        return w;
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic end_access;
        int n;
        n = 0;
        do begin
            @(negedge mclk);
            n++;
        end while (!wb_ack && n < ack_limit);
        if (!wb_ack) begin
            tb_errors++;
            $display("error at %0t: bus access to %h got no ack", $time, wb_adr);
        end
        @(negedge mclk);                                 // hold through the ack edge
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic write_word(input logic [11:0] adr, input logic [31:0] dat);
        @(negedge mclk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = dat;
        end_access();
    endtask

    task automatic read_word(input logic [11:0] adr, output logic [31:0] dat);
        @(negedge mclk);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_adr = adr;
        end_access();
        dat = wb_dat_r;
    endtask

    task automatic run_row(input row_t row);
        ddr_seq_pkg::cmd_word_u w;
        logic [31:0]            v;
        logic [11:0]            adr;
        int                     i;
        int                     n;
        adr = {1'b0, row.bank, row.start};
        for (i = 0; i <= row.count && row.count != 0; i++) begin
            if (i == row.pause_pos) begin
                write_word(adr, nop_word(1'b0, row.pause_len));
                adr++;
            end
            if (i < row.count) begin
                take_bits(23, v);
                w = v;                                   // odt down to address
                if (w.cmd.ras_n && w.cmd.cas_n && w.cmd.we_n)
                    w.cmd.we_n = 1'b0;                   // keep it a real command
                write_word(adr, w);
                adr++;
            end
        end
        if (row.count != 0)
            write_word(adr, nop_word(1'b1, 6'h2a));      // pause of a done word is ignored
        v = '0;
        v[ddr_seq_pkg::run_go_bit]   = 1'b1;
        v[ddr_seq_pkg::run_bank_bit] = row.bank;
        v[9:0]                       = row.start;
        write_word(run_adr, v);
        if (row.second_go)
            write_word(run_adr, v);                      // sequencer is busy by now
        n = 0;
        do begin
            read_word(stat_adr, v);
            n++;
        end while (!v[ddr_seq_pkg::stat_done_bit] && n < poll_limit);
        if (!v[ddr_seq_pkg::stat_done_bit]) begin
            tb_errors++;
            $display("error at %0t: sequence at bank %0d word %0d never finished", $time,
                     row.bank, row.start);
        end
    endtask

    initial begin
        mclk = 1'b0;
        forever #5 mclk = ~mclk;
    end

    initial begin
        int r;
        int total;
        rst       = 1'b1;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        lfsr      = 32'h280297f6;
        tb_errors = 0;
        repeat (10) @(negedge mclk);
        rst = 1'b0;
        for (r = 0; r < n_rows; r++)
            run_row(rows[r]);
        repeat (4) @(negedge mclk);
        total = tb_errors + chk_errors + ddr_seq_top_inst.seq_ctrl_inst.props_inst.fails;
        $display("errors: testbench %0d, checker %0d, assertions %0d", tb_errors, chk_errors,
                 ddr_seq_top_inst.seq_ctrl_inst.props_inst.fails);
        if (total == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/ddr_seq_props.sv */
// assertions on the sequencer outputs and their bind to seq_ctrl
`timescale 1ns/1ps
`default_nettype none

module ddr_seq_props (
    input wire                        mclk,
    input wire                        rst,
    input wire                        run_start,
    input wire                        cmd_valid,
    input wire                        busy,
    input wire                        done_pulse,
    input wire ddr_seq_pkg::ddr_cmd_t cmd
);

    int   fails = 0;                                // failed assertion count
    logic started;                                  // a run_start was seen

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            started <= 1'b0;
        end else if (run_start) begin
            started <= 1'b1;
        end
    end

    no_nop_out: assert property (@(posedge mclk) disable iff (rst)
        cmd_valid |-> !(cmd.ras_n && cmd.cas_n && cmd.we_n))
        else begin
            fails++;
            $error("nop encoding sent with cmd_valid");
        end

    done_in_busy: assert property (@(posedge mclk) disable iff (rst)
        done_pulse |-> busy)
        else begin
            fails++;
            $error("done_pulse while not busy");
        end

    quiet_until_start: assert property (@(posedge mclk) disable iff (rst)
        !started |-> !cmd_valid && !done_pulse)
        else begin
            fails++;
            $error("sequencer output active before the first run_start");
        end

endmodule

bind seq_ctrl ddr_seq_props props_inst (
    .mclk(mclk), .rst(rst), .run_start(run_start), .cmd_valid(cmd_valid),
    .busy(busy), .done_pulse(done_pulse), .cmd(cmd)
);

`default_nettype wire

/* testbench/ddr_seq_checker.sv */
// bus snooping memory image, command stream prediction, status and ack checks
`timescale 1ns/1ps
`default_nettype none

module ddr_seq_checker (
    input  wire                                   mclk,
    input  wire                                   rst,
    input  wire                                   wb_cyc,
    input  wire                                   wb_stb,
    input  wire                                   wb_we,
    input  wire [ddr_seq_pkg::wb_addr_bits-1:0]   wb_adr,
    input  wire [ddr_seq_pkg::wb_data_bits-1:0]   wb_dat_w,
    input  wire                                   wb_ack,
    input  wire [ddr_seq_pkg::wb_data_bits-1:0]   wb_dat_r,
    input  wire ddr_seq_pkg::ddr_cmd_t            cmd,
    input  wire                                   cmd_valid,
    output int                                    errors
);

    localparam int img_words = 2 << ddr_seq_pkg::cmd_addr_bits;    // both banks

    ddr_seq_pkg::cmd_word_u img [0:img_words-1];    // bank bit above the word address
    ddr_seq_pkg::ddr_cmd_t  exp_cmd [$];            // predicted commands in order
    int                     exp_slot [$];           // cycle of each, counted from the run ack
    int                     rel;                    // cycles since the accepted start
    int                     done_rel;               // cycle where the done nop is examined
    int                     wait_cnt;               // strobe cycles not yet acked
    logic                   started;
    logic                   cur_busy;
    logic                   cur_start;
    logic                   prev_idle;              // a go in this cycle gets through
    logic [31:0]            cur_status;
    logic [31:0]            prev_status;            // what a read strobed last cycle returns
    logic [31:0]            exp_dat;

    // walk the image from the start word up to the done nop
    task automatic predict(input logic bank, input logic [ddr_seq_pkg::cmd_addr_bits-1:0] start);
        ddr_seq_pkg::cmd_word_u                w;
        logic [ddr_seq_pkg::cmd_addr_bits-1:0] a;
        int                                    slot;
        int                                    n;
        exp_cmd.delete();
        exp_slot.delete();
        a        = start;
        slot     = 2;                               // first word out 2 cycles after the ack
        done_rel = -1;
        for (n = 0; n < img_words / 2 && done_rel < 0; n++) begin
            w = img[{bank, a}];
            if (w.cmd.ras_n && w.cmd.cas_n && w.cmd.we_n) begin
                if (w.nop.done)
                    done_rel = slot - 1;            // examined a cycle ahead of its slot
                else
                    slot += 1 + w.nop.pause;        // own slot plus the pause
            end else begin
                exp_cmd.push_back({w.cmd.odt, w.cmd.cke, w.cmd.ras_n, w.cmd.cas_n,
                                   w.cmd.we_n, w.cmd.bank, w.cmd.addr});
                exp_slot.push_back(slot);
                slot++;
            end
            a++;
        end
        if (done_rel < 0) begin
            errors++;
            $display("error at %0t: no done word in bank %0d after word %0d", $time, bank, start);
            done_rel = slot;
        end
    endtask

    always @(posedge mclk) begin
        if (rst) begin
            errors      = 0;
            rel         = 0;
            done_rel    = 0;
            wait_cnt    = 0;
            started     = 1'b0;
            prev_idle   = 1'b1;
            prev_status = '0;
            exp_cmd.delete();
            exp_slot.delete();
        end else begin
            // expected run_start, busy and done for the cycle just ended
            cur_start  = started && rel == 0;
            cur_busy   = started && rel >= 1 && rel <= done_rel;
            cur_status = '0;
            cur_status[ddr_seq_pkg::stat_busy_bit] = cur_busy;
            cur_status[ddr_seq_pkg::stat_done_bit] = started && rel > done_rel;
            if (exp_slot.size() != 0 && exp_slot[0] == rel) begin
                if (!cmd_valid) begin
                    errors++;
                    $display("mismatch at %0t: cmd_valid got 0 expected 1", $time);
                end else if (cmd !== exp_cmd[0]) begin
                    errors++;
                    $display("mismatch at %0t: cmd got %h expected %h", $time, cmd, exp_cmd[0]);
                end
                void'(exp_slot.pop_front());
                void'(exp_cmd.pop_front());
            end else if (cmd_valid) begin
                errors++;
                $display("mismatch at %0t: cmd_valid got 1 expected 0", $time);
            end
            if (wb_cyc && wb_stb && !wb_ack) begin
                wait_cnt++;
                if (wait_cnt == 2) begin
                    errors++;
                    $display("error at %0t: no ack in the cycle after the strobe", $time);
                end
            end else if (wb_cyc && wb_stb) begin
                if (wait_cnt != 1) begin
                    errors++;
                    $display("error at %0t: ack came %0d cycles after the strobe", $time, wait_cnt);
                end
                wait_cnt = 0;
                exp_dat  = (wb_adr == ((1 << ddr_seq_pkg::wb_reg_bit) | ddr_seq_pkg::reg_status))
                           ? prev_status : '0;      // memory reads give zero
                if (wb_we && !wb_adr[ddr_seq_pkg::wb_reg_bit]) begin
                    img[wb_adr[ddr_seq_pkg::cmd_addr_bits:0]] = wb_dat_w;
                end else if (wb_we && wb_adr[ddr_seq_pkg::wb_addr_bits-2:0] ==
                             ddr_seq_pkg::reg_run && wb_dat_w[ddr_seq_pkg::run_go_bit] &&
                             prev_idle) begin
                    predict(wb_dat_w[ddr_seq_pkg::run_bank_bit],
                            wb_dat_w[ddr_seq_pkg::cmd_addr_bits-1:0]);
                    started   = 1'b1;
                    rel       = 0;                  // this ack cycle carries run_start
                    cur_start = 1'b1;
                end else if (!wb_we && wb_dat_r !== exp_dat) begin
                    errors++;
                    $display("mismatch at %0t: wb_dat_r got %h expected %h", $time,
                             wb_dat_r, exp_dat);
                end
            end else if (wb_ack) begin
                errors++;
                $display("error at %0t: ack without a strobe", $time);
            end
            prev_status = cur_status;
            prev_idle   = !cur_busy && !cur_start;
            rel++;
        end
    end

endmodule

`default_nettype wire

/* logic/ddr_seq_top.sv */
// ddr_seq_top: register block, manual and auto command memories and the sequencer
`timescale 1ns/1ps
`default_nettype none

module ddr_seq_top #(
    parameter int cmd_addr_bits = ddr_seq_pkg::cmd_addr_bits
) (
    input  wire                                    mclk,
    input  wire                                    rst,
    // wishbone classic slave
    input  wire                                    wb_cyc,
    input  wire                                    wb_stb,
    input  wire                                    wb_we,
    input  wire [ddr_seq_pkg::wb_addr_bits-1:0]    wb_adr,
    input  wire [ddr_seq_pkg::wb_data_bits-1:0]    wb_dat_w,
    output logic                                   wb_ack,
    output logic [ddr_seq_pkg::wb_data_bits-1:0]   wb_dat_r,
    // phy command port
    output ddr_seq_pkg::ddr_cmd_t                  cmd,
    output logic                                   cmd_valid
);

    // bus to memories
    logic                                   mem_we0;
    logic                                   mem_we1;
    logic [ddr_seq_pkg::cmd_addr_bits-1:0]  mem_addr;
    ddr_seq_pkg::cmd_word_u                 mem_data;

    // register block to sequencer
    logic                                   run_start;
    ddr_seq_pkg::run_req_t                  run_req;
    logic                                   busy;
    logic                                   done_pulse;

    // sequencer to memories
    logic                                   rd_en;
    logic [cmd_addr_bits-1:0]               rd_addr;
    ddr_seq_pkg::cmd_word_u                 rd_data0;
    ddr_seq_pkg::cmd_word_u                 rd_data1;

    seq_regs seq_regs_inst (
        .mclk       (mclk),
        .rst        (rst),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_ack     (wb_ack),
        .wb_dat_r   (wb_dat_r),
        .mem_we0    (mem_we0),
        .mem_we1    (mem_we1),
        .mem_addr   (mem_addr),
        .mem_data   (mem_data),
        .run_start  (run_start),
        .run_req    (run_req),
        .busy       (busy),
        .done_pulse (done_pulse)
    );

    // bank 0, software sequences: mode set, refresh, levelling
    cmd_mem #(
        .depth_bits (cmd_addr_bits)
    ) bank0_mem_inst (
        .mclk    (mclk),
        .we      (mem_we0),
        .waddr   (mem_addr[cmd_addr_bits-1:0]),
        .wdata   (mem_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data0)
    );

    // bank 1, page read and write sequences
    cmd_mem #(
        .depth_bits (cmd_addr_bits)
    ) bank1_mem_inst (
        .mclk    (mclk),
        .we      (mem_we1),
        .waddr   (mem_addr[cmd_addr_bits-1:0]),
        .wdata   (mem_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data1)
    );

    seq_ctrl #(
        .depth_bits (cmd_addr_bits)
    ) seq_ctrl_inst (
        .mclk       (mclk),
        .rst        (rst),
        .run_start  (run_start),
        .run_req    (run_req),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_data0   (rd_data0),
        .rd_data1   (rd_data1),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .busy       (busy),
        .done_pulse (done_pulse)
    );

endmodule

`default_nettype wire

/* sequencer/seq_ctrl.sv */
// seq_ctrl: fetch address counter, nop decode, pause counter, done detection, command output
`timescale 1ns/1ps
`default_nettype none

module seq_ctrl #(
    parameter int depth_bits = ddr_seq_pkg::cmd_addr_bits
) (
    input  wire                          mclk,
    input  wire                          rst,
    // start request from the register block
    input  wire                          run_start,
    input  wire ddr_seq_pkg::run_req_t   run_req,
    // command memory read port, both banks
    output logic                         rd_en,
    output logic [depth_bits-1:0]        rd_addr,
    input  wire ddr_seq_pkg::cmd_word_u  rd_data0,
    input  wire ddr_seq_pkg::cmd_word_u  rd_data1,
    // to the phy
    output ddr_seq_pkg::ddr_cmd_t        cmd,
    output logic                         cmd_valid,
    // status
    output logic                         busy,
    output logic                         done_pulse
);

    logic [depth_bits-1:0]               addr_q;      // next word to fetch
    logic                                bank_sel;    // 0 manual, 1 auto
    logic                                word_vld;    // rd_data holds a fresh word
    logic [ddr_seq_pkg::pause_bits-1:0]  pause_cnt;   // remaining idle cycles
    ddr_seq_pkg::cmd_word_u              word;        // word under examination
    logic                                is_nop;
    logic                                pause_now;   // nop with pause seen this cycle
    logic                                hold;        // no fetch this cycle

    // bank mux on the registered memory outputs
    assign word = bank_sel ? rd_data1 : rd_data0;

    // nop decode through the nop view
    assign is_nop = word.nop.ras_n & word.nop.cas_n & word.nop.we_n;

    // end of sequence, pause field ignored
    assign done_pulse = word_vld & is_nop & word.nop.done;

    assign pause_now = word_vld & is_nop & ~word.nop.done & (word.nop.pause != '0);

    // the word after a pause nop is already addressed, keep it until the count runs out
    assign hold = pause_now | (pause_cnt > ddr_seq_pkg::pause_bits'(1));

    // first fetch straight from the request, so data is back one cycle after start
    assign rd_en   = run_start | (busy & ~hold & ~done_pulse);
    assign rd_addr = run_start ? run_req.addr[depth_bits-1:0] : addr_q;

    // sequence state and fetch
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            busy      <= 1'b0;
            bank_sel  <= 1'b0;
            word_vld  <= 1'b0;
            addr_q    <= '0;
            pause_cnt <= '0;
        end else begin
            if (run_start) begin
                busy     <= 1'b1;
                bank_sel <= run_req.bank;
            end else if (done_pulse) begin
                busy     <= 1'b0;                            // falls right after done nop
            end
            word_vld <= rd_en;                               // fetched word lands next cycle
            if (rd_en) begin
                addr_q <= rd_addr + depth_bits'(1);          // wraps at end of bank
            end
            if (pause_now) begin
                pause_cnt <= word.nop.pause;
            end else if (pause_cnt != '0) begin
                pause_cnt <= pause_cnt - ddr_seq_pkg::pause_bits'(1);
            end
        end
    end

    // output register, nops never leave
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            cmd       <= ddr_seq_pkg::cmd_idle;
            cmd_valid <= 1'b0;
        end else begin
            if (word_vld & ~is_nop) begin
                cmd.odt   <= word.cmd.odt;
                cmd.cke   <= word.cmd.cke;
                cmd.ras_n <= word.cmd.ras_n;
                cmd.cas_n <= word.cmd.cas_n;
                cmd.we_n  <= word.cmd.we_n;
                cmd.bank  <= word.cmd.bank;
                cmd.addr  <= word.cmd.addr;                 // ddr3 address view
                cmd_valid <= 1'b1;
            end else begin
                // idle: drive nop, keep cke, odt, bank and address
                cmd.ras_n <= 1'b1;
                cmd.cas_n <= 1'b1;
                cmd.we_n  <= 1'b1;
                cmd_valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* sequencer/seq_regs.sv */
// seq_regs: wishbone classic slave, run and status registers, command memory write routing
`timescale 1ns/1ps
`default_nettype none

module seq_regs (
    input  wire                                        mclk,
    input  wire                                        rst,
    // wishbone classic slave
    input  wire                                        wb_cyc,
    input  wire                                        wb_stb,
    input  wire                                        wb_we,
    input  wire [ddr_seq_pkg::wb_addr_bits-1:0]        wb_adr,
    input  wire [ddr_seq_pkg::wb_data_bits-1:0]        wb_dat_w,
    output logic                                       wb_ack,
    output logic [ddr_seq_pkg::wb_data_bits-1:0]       wb_dat_r,
    // command memory write port, shared by both banks
    output logic                                       mem_we0,
    output logic                                       mem_we1,
    output logic [ddr_seq_pkg::cmd_addr_bits-1:0]      mem_addr,
    output ddr_seq_pkg::cmd_word_u                     mem_data,
    // sequencer control
    output logic                                       run_start,
    output ddr_seq_pkg::run_req_t                      run_req,
    input  wire                                        busy,
    input  wire                                        done_pulse
);

    logic                                    req;         // strobe not yet acked
    logic                                    reg_sel;     // register space hit
    logic [ddr_seq_pkg::wb_addr_bits-2:0]    reg_off;     // offset in register space
    logic                                    mem_wr;      // write into a bank
    logic                                    wr_run;      // write to reg_run
    logic                                    rd_status;   // read of reg_status
    logic                                    go_ok;       // go allowed now
    logic                                    done;        // sticky done
    logic [ddr_seq_pkg::wb_data_bits-1:0]    status_word;

    // address decode
    assign req     = wb_cyc & wb_stb & ~wb_ack;
    assign reg_sel = wb_adr[ddr_seq_pkg::wb_reg_bit];
    assign reg_off = wb_adr[ddr_seq_pkg::wb_addr_bits-2:0];

    assign mem_wr    = req & wb_we & ~reg_sel;
    assign wr_run    = req & wb_we & reg_sel & (reg_off == ddr_seq_pkg::reg_run);
    assign rd_status = req & ~wb_we & reg_sel & (reg_off == ddr_seq_pkg::reg_status);

    // start only from idle, run_start covers the cycle before busy rises
    assign go_ok = wb_dat_w[ddr_seq_pkg::run_go_bit] & ~busy & ~run_start;

    always_comb begin
        status_word = '0;
        status_word[ddr_seq_pkg::stat_busy_bit] = busy;
        status_word[ddr_seq_pkg::stat_done_bit] = done;
    end

    // control: ack, write strobes, start pulse, sticky done
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            wb_ack    <= 1'b0;
            mem_we0   <= 1'b0;
            mem_we1   <= 1'b0;
            run_start <= 1'b0;
            done      <= 1'b0;
        end else begin
            wb_ack    <= req;                                      // single cycle ack
            mem_we0   <= mem_wr & ~wb_adr[ddr_seq_pkg::wb_bank_bit];
            mem_we1   <= mem_wr &  wb_adr[ddr_seq_pkg::wb_bank_bit];
            run_start <= wr_run & go_ok;                           // lines up with ack
            if (run_start) begin
                done <= 1'b0;                                      // new sequence
            end else if (done_pulse) begin
                done <= 1'b1;
            end
        end
    end

    // payload: write data, addresses and read data
    always_ff @(posedge mclk) begin
        if (req) begin
            mem_addr <= wb_adr[ddr_seq_pkg::cmd_addr_bits-1:0];
            mem_data <= wb_dat_w;
            wb_dat_r <= rd_status ? status_word : '0;              // memory reads give zero
        end
        if (wr_run) begin
            run_req.bank <= wb_dat_w[ddr_seq_pkg::run_bank_bit];
            run_req.addr <= wb_dat_w[ddr_seq_pkg::cmd_addr_bits-1:0];
        end
    end

endmodule

`default_nettype wire

/* logic/cmd_mem.sv */
// cmd_mem: one bank of sequencer command memory, bus write port, registered read port
`timescale 1ns/1ps
`default_nettype none

module cmd_mem #(
    parameter int depth_bits = ddr_seq_pkg::cmd_addr_bits
) (
    input  wire                        mclk,
    // write side, from the register block
    input  wire                        we,
    input  wire [depth_bits-1:0]       waddr,
    input  wire ddr_seq_pkg::cmd_word_u wdata,
    // read side, from the sequencer
    input  wire                        rd_en,
    input  wire [depth_bits-1:0]       rd_addr,
    output ddr_seq_pkg::cmd_word_u     rd_data
);

    localparam int words = 1 << depth_bits;

    ddr_seq_pkg::cmd_word_u mem [0:words-1];    // command words

    // bus writes
    always_ff @(posedge mclk) begin
        if (we) begin
            mem[waddr] <= wdata;                // full word, no byte lanes
        end
    end

    // output register, holds while rd_en is low
    always_ff @(posedge mclk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];            // old data on same-address write
        end
    end

endmodule

`default_nettype wire

/* common/ddr_seq_pkg.sv */
// sizes, register map, command word union, phy command and run request structs
`default_nettype none

package ddr_seq_pkg;

    localparam int cmd_addr_bits = 10;          // words per bank, log2
    localparam int sd_addr_bits  = 15;          // ddr3 row/column address
    localparam int sd_bank_bits  = 3;           // ddr3 bank address
    localparam int pause_bits    = 6;           // pause length inside a nop word
    localparam int wb_addr_bits  = 12;          // wishbone word address
    localparam int wb_data_bits  = 32;
    localparam int cmd_word_bits = 32;

    // upper bits of a command word carry nothing
    localparam int rsv_bits = cmd_word_bits - 5 - sd_bank_bits - sd_addr_bits;

    // wishbone address map
    localparam int wb_reg_bit  = wb_addr_bits - 1;  // set: register space
    localparam int wb_bank_bit = cmd_addr_bits;     // memory space: bank select

    // register offsets and fields
    localparam int reg_run       = 0;
    localparam int reg_status    = 1;
    localparam int run_go_bit    = 31;              // start request
    localparam int run_bank_bit  = 10;              // start bank
    localparam int stat_busy_bit = 0;
    localparam int stat_done_bit = 1;               // sticky

    // plain command view, address field is the ddr3 address
    typedef struct packed {
        logic [rsv_bits-1:0]     rsv;
        logic                    odt;
        logic                    cke;
        logic                    ras_n;
        logic                    cas_n;
        logic                    we_n;
        logic [sd_bank_bits-1:0] bank;
        logic [sd_addr_bits-1:0] addr;
    } cmd_view_t;

    // nop view, used when ras_n, cas_n and we_n are all high
    typedef struct packed {
        logic [rsv_bits-1:0]                  rsv;
        logic                                 odt;
        logic                                 cke;
        logic                                 ras_n;
        logic                                 cas_n;
        logic                                 we_n;
        logic [sd_bank_bits-1:0]              bank;
        logic [sd_addr_bits-pause_bits-2:0]   spare;
        logic                                 done;   // end of sequence
        logic [pause_bits-1:0]                pause;  // idle cycles after this word
    } nop_view_t;

    typedef union packed {
        cmd_view_t cmd;
        nop_view_t nop;
    } cmd_word_u;

    // one command to the phy, same bit order as the low word bits
    typedef struct packed {
        logic                    odt;
        logic                    cke;
        logic                    ras_n;
        logic                    cas_n;
        logic                    we_n;
        logic [sd_bank_bits-1:0] bank;
        logic [sd_addr_bits-1:0] addr;
    } ddr_cmd_t;

    // nop with cke low, what the phy sees out of reset
    localparam ddr_cmd_t cmd_idle = '{
        odt:   1'b0,
        cke:   1'b0,
        ras_n: 1'b1,
        cas_n: 1'b1,
        we_n:  1'b1,
        bank:  '0,
        addr:  '0
    };

    typedef struct packed {
        logic                     bank;   // 0 manual, 1 auto
        logic [cmd_addr_bits-1:0] addr;   // first word
    } run_req_t;

endpackage

`default_nettype wire
